/* logic/rr_pkg.sv */
package rr_pkg;

    // widths that carry a meaning
    typedef logic [31:0] csr_word_t;
    typedef logic [3:0]  csr_idx_t;
    typedef logic [63:0] host_addr_t;
    typedef logic [31:0] trace_word_t;
    typedef logic [63:0] beat_t;
    typedef logic [31:0] count_t;

    localparam int unsigned AXIL_ADDR_W = 32;

    // address step per beat
    localparam host_addr_t BEAT_BYTES = 64'd8;

    // register indexes, taken from address bits 5:2
    localparam csr_idx_t REG_BUF_ADDR_HI   = 4'd0;
    localparam csr_idx_t REG_BUF_ADDR_LO   = 4'd1;
    localparam csr_idx_t REG_BUF_SIZE_HI   = 4'd2;
    localparam csr_idx_t REG_BUF_SIZE_LO   = 4'd3;
    localparam csr_idx_t REG_BUF_UPDATE    = 4'd4;
    localparam csr_idx_t REG_FORCE_FINISH  = 4'd5;
    localparam csr_idx_t REG_BYTES_WRITTEN = 4'd6;
    localparam csr_idx_t REG_BEATS_DROPPED = 4'd7;

    // axi-lite, master to slave
    typedef struct packed {
        logic                   awvalid;
        logic [AXIL_ADDR_W-1:0] awaddr;
        logic                   wvalid;
        csr_word_t              wdata;
        logic [3:0]             wstrb;
        logic                   bready;
        logic                   arvalid;
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   rready;
    } axil_req_t;

    // axi-lite, slave to master
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        csr_word_t  rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

    // one host memory write
    typedef struct packed {
        host_addr_t addr;
        beat_t      data;
    } mem_wr_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_RUN,
        WR_FULL
    } wr_state_t;

endpackage

/* logic/rr_csrs.sv */
module rr_csrs (
    input  logic               clk,
    input  logic               rstn,
    input  rr_pkg::axil_req_t  axil_req,
    output rr_pkg::axil_rsp_t  axil_rsp,
    input  rr_pkg::count_t     bytes_written,
    input  rr_pkg::count_t     beats_dropped,
    output rr_pkg::host_addr_t buf_addr,
    output rr_pkg::host_addr_t buf_size,
    output logic               buf_update,
    output logic               force_finish
);

    // configuration registers, indexes 0 to 3
    rr_pkg::csr_word_t cfg_q [4];

    logic              awready;
    logic              wready;
    logic              aw_fire;
    logic              w_fire;
    logic              aw_held_q;
    logic              w_held_q;
    rr_pkg::csr_idx_t  aw_idx_q;
    rr_pkg::csr_word_t w_data_q;
    rr_pkg::csr_word_t w_mask_q;
    rr_pkg::csr_word_t w_mask;
    logic              wr_done;
    rr_pkg::csr_idx_t  wr_idx;
    rr_pkg::csr_word_t wr_data;
    rr_pkg::csr_word_t wr_mask;
    logic              bvalid_q;
    logic              b_stall;

    logic              arready;
    logic              ar_fire;
    logic              rvalid_q;
    rr_pkg::csr_word_t rdata_q;
    rr_pkg::csr_idx_t  rd_idx;
    rr_pkg::csr_word_t rd_data;

    // no new write while the response waits for bready
    assign b_stall = bvalid_q & ~axil_req.bready;
    assign awready = ~aw_held_q & ~b_stall;
    assign wready  = ~w_held_q & ~b_stall;
    assign aw_fire = axil_req.awvalid & awready;
    assign w_fire  = axil_req.wvalid & wready;

    // complete once both halves are in, in either order
    assign wr_done = (aw_fire | aw_held_q) & (w_fire | w_held_q);

    // byte strobes to bit mask
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            w_mask[8*i +: 8] = {8{axil_req.wstrb[i]}};
        end
    end

    // the channel arriving this cycle wins over the held copy
    assign wr_idx  = aw_fire ? axil_req.awaddr[5:2] : aw_idx_q;
    assign wr_data = w_fire ? axil_req.wdata : w_data_q;
    assign wr_mask = w_fire ? w_mask : w_mask_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
        end else begin
            if (wr_done) begin
                aw_held_q <= 1'b0;
            end else if (aw_fire) begin
                aw_held_q <= 1'b1;
            end
            if (wr_done) begin
                w_held_q <= 1'b0;
            end else if (w_fire) begin
                w_held_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            aw_idx_q <= axil_req.awaddr[5:2];
        end
        if (w_fire) begin
            w_data_q <= axil_req.wdata;
            w_mask_q <= w_mask;
        end
    end

    // strobed merge into the config registers
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 4; i++) begin
                cfg_q[i] <= '0;
            end
        end else if (wr_done && wr_idx <= rr_pkg::REG_BUF_SIZE_LO) begin
            cfg_q[wr_idx[1:0]] <= (wr_data & wr_mask) | (cfg_q[wr_idx[1:0]] & ~wr_mask);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            bvalid_q     <= 1'b0;
            buf_update   <= 1'b0;
            force_finish <= 1'b0;
        end else begin
            if (wr_done) begin
                bvalid_q <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
            // single cycle pulses
            buf_update   <= wr_done && (wr_idx == rr_pkg::REG_BUF_UPDATE);
            force_finish <= wr_done && (wr_idx == rr_pkg::REG_FORCE_FINISH);
        end
    end

    // read side
    assign arready = ~(rvalid_q & ~axil_req.rready);
    assign ar_fire = axil_req.arvalid & arready;
    assign rd_idx  = axil_req.araddr[5:2];

    always_comb begin
        case (rd_idx)
            rr_pkg::REG_BUF_ADDR_HI:   rd_data = cfg_q[0];
            rr_pkg::REG_BUF_ADDR_LO:   rd_data = cfg_q[1];
            rr_pkg::REG_BUF_SIZE_HI:   rd_data = cfg_q[2];
            rr_pkg::REG_BUF_SIZE_LO:   rd_data = cfg_q[3];
            rr_pkg::REG_BYTES_WRITTEN: rd_data = bytes_written;
            rr_pkg::REG_BEATS_DROPPED: rd_data = beats_dropped;
            // pulse registers and unused indexes
            default:                   rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rvalid_q <= 1'b0;
        end else if (ar_fire) begin
            rvalid_q <= 1'b1;
        end else if (axil_req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    // data sampled at ar acceptance
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata_q <= rd_data;
        end
    end

    always_comb begin
        axil_rsp         = '0;
        axil_rsp.awready = awready;
        axil_rsp.wready  = wready;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = 2'b00;
        axil_rsp.arready = arready;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = 2'b00;
    end

    assign buf_addr = {cfg_q[0], cfg_q[1]};
    assign buf_size = {cfg_q[2], cfg_q[3]};

endmodule

/* logic/rr_trace_packer.sv */
module rr_trace_packer (
    input  logic                clk,
    input  logic                rstn,
    input  logic                trace_valid,
    input  rr_pkg::trace_word_t trace_word,
    output logic                trace_ready,
    input  logic                force_finish,
    output logic                beat_valid,
    output rr_pkg::beat_t       beat,
    input  logic                beat_ready
);

    rr_pkg::trace_word_t half_q;
    logic                half_full_q;
    logic                flush_pend_q;
    rr_pkg::beat_t       beat_q;
    logic                beat_valid_q;

    logic slot_free;
    logic trace_fire;
    logic pair_done;
    logic flush_req;
    logic flush;

    // output register empty or emptying this cycle
    assign slot_free   = ~beat_valid_q | beat_ready;
    assign trace_ready = slot_free;
    assign trace_fire  = trace_valid & trace_ready;
    assign pair_done   = trace_fire & half_full_q;

    // a flush waits for the output slot; a completed pair makes it moot
    assign flush_req = (force_finish | flush_pend_q) & half_full_q;
    assign flush     = flush_req & slot_free & ~trace_fire;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            half_full_q  <= 1'b0;
            flush_pend_q <= 1'b0;
            beat_valid_q <= 1'b0;
        end else begin
            if (pair_done || flush) begin
                half_full_q <= 1'b0;
            end else if (trace_fire) begin
                half_full_q <= 1'b1;
            end
            flush_pend_q <= flush_req & ~pair_done & ~flush;
            if (pair_done || flush) begin
                beat_valid_q <= 1'b1;
            end else if (beat_ready) begin
                beat_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trace_fire && !half_full_q) begin
            half_q <= trace_word;
        end
        // first word of the pair goes low
        if (pair_done) begin
            beat_q <= {trace_word, half_q};
        end else if (flush) begin
            beat_q <= {32'h0, half_q};
        end
    end

    assign beat_valid = beat_valid_q;
    assign beat       = beat_q;

endmodule

/* logic/rr_trace_writer.sv */
module rr_trace_writer (
    input  logic               clk,
    input  logic               rstn,
    input  rr_pkg::host_addr_t buf_addr,
    input  rr_pkg::host_addr_t buf_size,
    input  logic               buf_update,
    input  logic               beat_valid,
    input  rr_pkg::beat_t      beat,
    output logic               beat_ready,
    output logic               mem_valid,
    output rr_pkg::mem_wr_t    mem_req,
    input  logic               mem_ready,
    output rr_pkg::count_t     bytes_written,
    output rr_pkg::count_t     beats_dropped
);

    rr_pkg::wr_state_t  state_q;
    rr_pkg::host_addr_t offset_q;
    rr_pkg::host_addr_t next_offset;
    logic               mem_valid_q;
    rr_pkg::mem_wr_t    mem_req_q;
    rr_pkg::count_t     bytes_q;
    rr_pkg::count_t     dropped_q;
    logic               upd_pend_q;

    logic upd_req;
    logic upd_apply;
    logic beat_fire;
    logic mem_fire;
    logic no_room;

    assign upd_req   = buf_update | upd_pend_q;
    // update waits for an outstanding request to finish
    assign upd_apply = upd_req & (~mem_valid_q | mem_ready);
    assign mem_fire  = mem_valid_q & mem_ready;

    always_comb begin
        beat_ready = 1'b0;
        if (!upd_req) begin
            case (state_q)
                rr_pkg::WR_RUN:  beat_ready = ~mem_valid_q;
                rr_pkg::WR_FULL: beat_ready = 1'b1;
                default:         beat_ready = 1'b0;
            endcase
        end
    end

    assign beat_fire   = beat_valid & beat_ready;
    assign next_offset = offset_q + rr_pkg::BEAT_BYTES;
    assign no_room     = next_offset > buf_size;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q     <= rr_pkg::WR_IDLE;
            offset_q    <= '0;
            mem_valid_q <= 1'b0;
            bytes_q     <= '0;
            dropped_q   <= '0;
            upd_pend_q  <= 1'b0;
        end else begin
            upd_pend_q <= upd_req & ~upd_apply;
            if (mem_fire) begin
                mem_valid_q <= 1'b0;
                bytes_q     <= bytes_q + rr_pkg::count_t'(rr_pkg::BEAT_BYTES);
            end
            if (upd_apply) begin
                state_q   <= rr_pkg::WR_RUN;
                offset_q  <= '0;
                bytes_q   <= '0;
                dropped_q <= '0;
            end else if (beat_fire) begin
                if (state_q == rr_pkg::WR_FULL || no_room) begin
                    // beat goes nowhere
                    state_q   <= rr_pkg::WR_FULL;
                    dropped_q <= dropped_q + 1'b1;
                end else begin
                    mem_valid_q <= 1'b1;
                    offset_q    <= next_offset;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_fire && state_q == rr_pkg::WR_RUN && !no_room) begin
            mem_req_q.addr <= buf_addr + offset_q;
            mem_req_q.data <= beat;
        end
    end

    assign mem_valid     = mem_valid_q;
    assign mem_req       = mem_req_q;
    assign bytes_written = bytes_q;
    assign beats_dropped = dropped_q;

endmodule

/* logic/rr_logger_top.sv */
module rr_logger_top (
    input  logic                clk,
    input  logic                rstn,
    input  rr_pkg::axil_req_t   axil_req,
    output rr_pkg::axil_rsp_t   axil_rsp,
    input  logic                trace_valid,
    input  rr_pkg::trace_word_t trace_word,
    output logic                trace_ready,
    output logic                mem_valid,
    output rr_pkg::mem_wr_t     mem_req,
    input  logic                mem_ready
);

    // csr levels and pulses
    rr_pkg::host_addr_t buf_addr;
    rr_pkg::host_addr_t buf_size;
    logic               buf_update;
    logic               force_finish;

    // status back from the writer
    rr_pkg::count_t     bytes_written;
    rr_pkg::count_t     beats_dropped;

    // packer to writer
    logic               beat_valid;
    rr_pkg::beat_t      beat;
    logic               beat_ready;

    rr_csrs i_csrs (
        .clk           (clk),
        .rstn          (rstn),
        .axil_req      (axil_req),
        .axil_rsp      (axil_rsp),
        .bytes_written (bytes_written),
        .beats_dropped (beats_dropped),
        .buf_addr      (buf_addr),
        .buf_size      (buf_size),
        .buf_update    (buf_update),
        .force_finish  (force_finish)
    );

    rr_trace_packer i_packer (
        .clk          (clk),
        .rstn         (rstn),
        .trace_valid  (trace_valid),
        .trace_word   (trace_word),
        .trace_ready  (trace_ready),
        .force_finish (force_finish),
        .beat_valid   (beat_valid),
        .beat         (beat),
        .beat_ready   (beat_ready)
    );

    rr_trace_writer i_writer (
        .clk           (clk),
        .rstn          (rstn),
        .buf_addr      (buf_addr),
        .buf_size      (buf_size),
        .buf_update    (buf_update),
        .beat_valid    (beat_valid),
        .beat          (beat),
        .beat_ready    (beat_ready),
        .mem_valid     (mem_valid),
        .mem_req       (mem_req),
        .mem_ready     (mem_ready),
        .bytes_written (bytes_written),
        .beats_dropped (beats_dropped)
    );

endmodule

/* tb/rr_logger_chk.sv */
module rr_logger_chk (
    input logic              clk,
    input logic              rstn,
    input rr_pkg::axil_req_t axil_req,
    input rr_pkg::axil_rsp_t axil_rsp,
    input logic              beat_valid,
    input logic              beat_ready,
    input logic              buf_update,
    input logic              force_finish,
    input logic              mem_valid,
    input rr_pkg::mem_wr_t   mem_req,
    input logic              mem_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench at the end of the run
    int unsigned assert_fails = 0;

    b_hold: assert property (@(posedge clk) disable iff (!rstn)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else begin
        assert_fails++;
        $error("bvalid dropped before bready");
    end

    r_hold: assert property (@(posedge clk) disable iff (!rstn)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
    else begin
        assert_fails++;
        $error("rvalid or rdata changed before rready");
    end

    // no new write while the response waits
    w_blocked: assert property (@(posedge clk) disable iff (!rstn)
        axil_rsp.bvalid && !axil_req.bready |-> !axil_rsp.awready && !axil_rsp.wready)
    else begin
        assert_fails++;
        $error("awready or wready high while bvalid waits");
    end

    mem_stable: assert property (@(posedge clk) disable iff (!rstn)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_req))
    else begin
        assert_fails++;
        $error("memory request changed while stalled");
    end

    reset_state: assert property (@(posedge clk)
        !rstn |=> !axil_rsp.bvalid && !axil_rsp.rvalid && !beat_valid && !beat_ready
                  && !mem_valid && !buf_update && !force_finish)
    else begin
        assert_fails++;
        $error("outputs not low after reset");
    end

endmodule

/* tb/rr_logger_tb.sv */
module rr_logger_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned CLK_NS = 4;
    localparam logic [31:0] SEED   = 32'h8e77_e5a4;
    // cycle budget per test with room for random mem_ready stalls
    localparam int unsigned CYC_RESET = 10;
    localparam int unsigned CYC_IDLE  = 50;
    localparam int unsigned CYC_REGS  = 500;
    localparam int unsigned CYC_BP    = 100;
    localparam int unsigned CYC_PACK  = 300;
    localparam int unsigned CYC_FLUSH = 200;
    localparam int unsigned CYC_FULL  = 400;
    localparam int unsigned LIMIT_NS  = CLK_NS * 2 * (CYC_RESET + CYC_IDLE + CYC_REGS
                                        + CYC_BP + CYC_PACK + CYC_FLUSH + CYC_FULL);

    logic                clk;
    logic                rstn;
    rr_pkg::axil_req_t   axil_req;
    rr_pkg::axil_rsp_t   axil_rsp;
    logic                trace_valid;
    rr_pkg::trace_word_t trace_word;
    logic                trace_ready;
    logic                mem_valid;
    rr_pkg::mem_wr_t     mem_req;
    logic                mem_ready;

    int unsigned         value_errors;
    int unsigned         proto_errors;
    logic [31:0]         word_seed;
    logic [31:0]         sink_seed;
    rr_pkg::csr_word_t   reg_model [4];
    rr_pkg::trace_word_t sent_words [$];
    rr_pkg::mem_wr_t     mem_seen [$];
    rr_pkg::host_addr_t  buf_base;

    rr_logger_top i_dut (
        .clk         (clk),
        .rstn        (rstn),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .trace_valid (trace_valid),
        .trace_word  (trace_word),
        .trace_ready (trace_ready),
        .mem_valid   (mem_valid),
        .mem_req     (mem_req),
        .mem_ready   (mem_ready)
    );

    bind rr_logger_top rr_logger_chk i_chk (
        .clk          (clk),
        .rstn         (rstn),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .beat_valid   (beat_valid),
        .beat_ready   (beat_ready),
        .buf_update   (buf_update),
        .force_finish (force_finish),
        .mem_valid    (mem_valid),
        .mem_req      (mem_req),
        .mem_ready    (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // memory sink ready about three cycles in four
    always @(posedge clk) begin
        if (!rstn) begin
            mem_ready <= 1'b0;
        end else begin
            if (mem_valid && mem_ready) begin
                mem_seen.push_back(mem_req);
            end
            sink_seed = lcg_step(sink_seed);
            mem_ready <= (sink_seed[31:30] != 2'b00);
        end
    end

    task automatic report_failure(input string what);
        proto_errors++;
        $display("%s at %0t ns", what, $time);
    endtask

    task automatic check_csr(input string what, input rr_pkg::csr_word_t got,
                             input rr_pkg::csr_word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input rr_pkg::count_t got,
                               input rr_pkg::count_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_mem(input string what, input rr_pkg::mem_wr_t got,
                             input rr_pkg::mem_wr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0t ns: %s is %h/%h, expected %h/%h", $time, what,
                     got.addr, got.data, exp.addr, exp.data);
        end
    endtask

    // order 0 sends aw and w together while 1 sends aw first and 2 sends w first
    task automatic axil_write(input rr_pkg::csr_idx_t idx, input rr_pkg::csr_word_t data,
                              input logic [3:0] strb, input int order, input int bwait);
        logic aw_done;
        logic w_done;
        int   gap;
        aw_done = 1'b0;
        w_done  = 1'b0;
        gap     = 0;
        @(posedge clk);
        axil_req.awaddr  <= {26'h0, idx, 2'b00};
        axil_req.wdata   <= data;
        axil_req.wstrb   <= strb;
        axil_req.bready  <= (bwait == 0);
        axil_req.awvalid <= (order != 2);
        axil_req.wvalid  <= (order != 1);
        while (!(aw_done && w_done)) begin
            @(posedge clk);
            if (axil_req.awvalid && axil_rsp.awready) begin
                aw_done = 1'b1;
                axil_req.awvalid <= 1'b0;
            end
            if (axil_req.wvalid && axil_rsp.wready) begin
                w_done = 1'b1;
                axil_req.wvalid <= 1'b0;
            end
            // second channel follows two cycles later
            if (aw_done != w_done) begin
                gap++;
                if (gap == 2) begin
                    axil_req.awvalid <= !aw_done;
                    axil_req.wvalid  <= !w_done;
                end
            end
        end
        do @(posedge clk); while (!axil_rsp.bvalid);
        if (axil_rsp.bresp != 2'b00) begin
            report_failure("write response is not OKAY");
        end
        if (bwait > 0) begin
            repeat (bwait) begin
                @(posedge clk);
                if (!axil_rsp.bvalid) begin
                    report_failure("bvalid dropped before bready");
                end
                if (axil_rsp.awready || axil_rsp.wready) begin
                    report_failure("a new write could be accepted while bvalid waits");
                end
            end
            axil_req.bready <= 1'b1;
            @(posedge clk);
        end
    endtask

    task automatic axil_read(input rr_pkg::csr_idx_t idx, input int rwait,
                             output rr_pkg::csr_word_t data);
        @(posedge clk);
        axil_req.araddr  <= {26'h0, idx, 2'b00};
        axil_req.arvalid <= 1'b1;
        axil_req.rready  <= (rwait == 0);
        do @(posedge clk); while (!axil_rsp.arready);
        axil_req.arvalid <= 1'b0;
        do @(posedge clk); while (!axil_rsp.rvalid);
        data = axil_rsp.rdata;
        if (axil_rsp.rresp != 2'b00) begin
            report_failure("read response is not OKAY");
        end
        if (rwait > 0) begin
            repeat (rwait) begin
                @(posedge clk);
                if (!axil_rsp.rvalid) begin
                    report_failure("rvalid dropped before rready");
                end
                check_csr("held read data", axil_rsp.rdata, data);
            end
            axil_req.rready <= 1'b1;
            @(posedge clk);
        end
    endtask

    task automatic write_model(input rr_pkg::csr_idx_t idx, input rr_pkg::csr_word_t data,
                               input logic [3:0] strb, input int order, input int bwait);
        axil_write(idx, data, strb, order, bwait);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                reg_model[idx[1:0]][8*i +: 8] = data[8*i +: 8];
            end
        end
    endtask

    task automatic expect_count(input rr_pkg::csr_idx_t idx, input rr_pkg::count_t exp,
                                input string what);
        rr_pkg::csr_word_t d;
        axil_read(idx, 0, d);
        check_count(what, rr_pkg::count_t'(d), exp);
    endtask

    task automatic send_words(input int n);
        @(posedge clk);
        for (int i = 0; i < n; i++) begin
            word_seed = lcg_step(word_seed);
            sent_words.push_back(rr_pkg::trace_word_t'(word_seed));
            trace_valid <= 1'b1;
            trace_word  <= rr_pkg::trace_word_t'(word_seed);
            do @(posedge clk); while (!trace_ready);
        end
        trace_valid <= 1'b0;
    endtask

    task automatic wait_mem(input int n);
        while (mem_seen.size() < n) begin
            @(posedge clk);
        end
    endtask

    // beat k goes to base + 8k with the first word low and an odd tail padded with zero
    task automatic check_placement();
        rr_pkg::mem_wr_t exp;
        for (int k = 0; k < mem_seen.size(); k++) begin
            exp.addr        = buf_base + rr_pkg::BEAT_BYTES * k;
            exp.data[31:0]  = sent_words[2*k];
            exp.data[63:32] = (2*k + 1 < sent_words.size()) ? sent_words[2*k+1] : '0;
            check_mem($sformatf("request %0d", k), mem_seen[k], exp);
        end
    endtask

    task automatic test_idle();
        send_words(2);
        repeat (4) @(posedge clk);
        if (trace_ready) begin
            report_failure("trace_ready stayed high with a beat pending and no buffer");
        end
        if (mem_seen.size() != 0 || mem_valid) begin
            report_failure("memory request appeared without a buffer update");
        end
    endtask

    task automatic test_registers();
        rr_pkg::csr_word_t d;
        write_model(rr_pkg::REG_BUF_ADDR_HI, 32'h1234_5678, 4'hf, 0, 0);
        write_model(rr_pkg::REG_BUF_ADDR_LO, 32'hcafe_f00d, 4'hf, 1, 0);
        write_model(rr_pkg::REG_BUF_SIZE_HI, 32'h0bad_beef, 4'hf, 2, 0);
        write_model(rr_pkg::REG_BUF_SIZE_LO, 32'hdead_0000, 4'hf, 0, 0);
        write_model(rr_pkg::REG_BUF_ADDR_HI, 32'haaaa_bbbb, 4'b0101, 1, 0);
        write_model(rr_pkg::REG_BUF_ADDR_LO, 32'h1111_2222, 4'b1000, 2, 0);
        write_model(rr_pkg::REG_BUF_SIZE_LO, 32'h3333_4444, 4'b0011, 0, 0);
        // a write to an unused index changes nothing
        axil_write(4'd9, 32'hffff_ffff, 4'hf, 1, 0);
        for (int i = 0; i < 16; i++) begin
            axil_read(rr_pkg::csr_idx_t'(i), 0, d);
            check_csr($sformatf("register %0d", i), d, (i < 4) ? reg_model[i] : '0);
        end
    endtask

    task automatic test_backpressure();
        rr_pkg::csr_word_t d;
        write_model(rr_pkg::REG_BUF_ADDR_LO, 32'h9abc_d000, 4'hf, 0, 5);
        axil_read(rr_pkg::REG_BUF_ADDR_LO, 6, d);
        check_csr("address low after stalled response", d, reg_model[1]);
    endtask

    task automatic program_buffer(input rr_pkg::host_addr_t base, input rr_pkg::host_addr_t size);
        write_model(rr_pkg::REG_BUF_ADDR_HI, base[63:32], 4'hf, 0, 0);
        write_model(rr_pkg::REG_BUF_ADDR_LO, base[31:0], 4'hf, 1, 0);
        write_model(rr_pkg::REG_BUF_SIZE_HI, size[63:32], 4'hf, 2, 0);
        write_model(rr_pkg::REG_BUF_SIZE_LO, size[31:0], 4'hf, 0, 0);
        buf_base = base;
        axil_write(rr_pkg::REG_BUF_UPDATE, 32'h1, 4'hf, 0, 0);
    endtask

    // the beat held since the idle test is written first
    task automatic test_packing();
        program_buffer(64'h0000_0001_2345_6000, 64'h1000);
        send_words(8);
        wait_mem(sent_words.size() / 2);
        check_placement();
        expect_count(rr_pkg::REG_BYTES_WRITTEN, 8 * (sent_words.size() / 2), "bytes written");
        if (mem_seen.size() != sent_words.size() / 2) begin
            report_failure("wrong number of memory requests after packing");
        end
    endtask

    task automatic test_force_finish();
        sent_words.delete();
        mem_seen.delete();
        axil_write(rr_pkg::REG_BUF_UPDATE, 32'h1, 4'hf, 0, 0);
        send_words(3);
        wait_mem(1);
        axil_write(rr_pkg::REG_FORCE_FINISH, 32'h1, 4'hf, 2, 0);
        wait_mem(2);
        check_placement();
        expect_count(rr_pkg::REG_BYTES_WRITTEN, 16, "bytes written after flush");
    endtask

    task automatic test_buffer_full();
        int beats;
        int room;
        beats = 5;
        room  = 3;
        sent_words.delete();
        mem_seen.delete();
        program_buffer(buf_base, rr_pkg::BEAT_BYTES * room);
        send_words(2 * beats);
        wait_mem(room);
        repeat (20) @(posedge clk);
        if (mem_seen.size() != room) begin
            report_failure("wrong number of memory requests with the buffer full");
        end
        check_placement();
        expect_count(rr_pkg::REG_BEATS_DROPPED, beats - room, "beats dropped");
        expect_count(rr_pkg::REG_BYTES_WRITTEN, 8 * room, "bytes written when full");
        axil_write(rr_pkg::REG_BUF_UPDATE, 32'h1, 4'hf, 1, 0);
        expect_count(rr_pkg::REG_BEATS_DROPPED, 0, "beats dropped after update");
        expect_count(rr_pkg::REG_BYTES_WRITTEN, 0, "bytes written after update");
        sent_words.delete();
        mem_seen.delete();
        send_words(2);
        wait_mem(1);
        check_placement();
    endtask

    initial begin
        #(LIMIT_NS);
        $display("timeout after %0d ns, the tests did not finish", LIMIT_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rstn         = 1'b0;
        axil_req     = '0;
        trace_valid  = 1'b0;
        trace_word   = '0;
        mem_ready    = 1'b0;
        value_errors = 0;
        proto_errors = 0;
        sink_seed    = SEED;
        word_seed    = lcg_step(SEED);
        buf_base     = '0;
        for (int i = 0; i < 4; i++) begin
            reg_model[i] = '0;
        end
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        test_idle();
        test_registers();
        test_backpressure();
        test_packing();
        test_force_finish();
        test_buffer_full();
        repeat (5) @(posedge clk);
        $display("errors: %0d wrong values, %0d protocol failures, %0d assertion failures",
                 value_errors, proto_errors, i_dut.i_chk.assert_fails);
        if (value_errors == 0 && proto_errors == 0 && i_dut.i_chk.assert_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
logic/rr_pkg.sv
logic/rr_csrs.sv
logic/rr_trace_packer.sv
logic/rr_trace_writer.sv
logic/rr_logger_top.sv
tb/rr_logger_chk.sv
tb/rr_logger_tb.sv

/* Bender.yml */
package:
  name: rr_logger

sources:
  - logic/rr_pkg.sv
  - logic/rr_csrs.sv
  - logic/rr_trace_packer.sv
  - logic/rr_trace_writer.sv
  - logic/rr_logger_top.sv
  - target: test
    files:
      - tb/rr_logger_chk.sv
      - tb/rr_logger_tb.sv
